// File: source/replay_settings.svh
/* Queue count, pointer and data widths, FIFO depths and the
   output FIFO programmable-full margin */

`ifndef REPLAY_SETTINGS_SVH
`define REPLAY_SETTINGS_SVH

// Queues and address split
`define REPLAY_NUM_QUEUES 4
`define REPLAY_QID_W 2
`define REPLAY_MEM_ADDR_W 12
`define REPLAY_PTR_W (`REPLAY_MEM_ADDR_W - `REPLAY_QID_W)

// One memory half-word
`define REPLAY_HALF_W 36

// Log2 depths of the tag, beat and output FIFOs
`define REPLAY_TAG_DEPTH_BITS 4
`define REPLAY_OUT_DEPTH_BITS 4

// Free entries left when prog_full rises, sized for reads in flight
`define REPLAY_OUT_PROG_MARGIN 6

`endif

// File: source/replay_pkg.sv
/* Shared types of the replay read engine: queue index, pointers,
   memory request and response, assembled word and per-queue vectors */

`include "replay_settings.svh"

package replay_pkg;

  // Queue index and ring pointer
  typedef logic [`REPLAY_QID_W-1:0] qid_t;
  typedef logic [`REPLAY_PTR_W-1:0] ptr_t;

  // Read request, address top bits select the queue
  typedef struct packed {
    logic                          valid;
    logic [`REPLAY_MEM_ADDR_W-1:0] addr;
  } mem_req_t;

  // One response beat, high half in the upper bits
  typedef struct packed {
    logic [`REPLAY_HALF_W-1:0] hi;
    logic [`REPLAY_HALF_W-1:0] lo;
  } mem_beat_t;

  typedef struct packed {
    logic      valid;
    mem_beat_t beat;
  } mem_resp_t;

  // Beat 1 high, beat 0 high, beat 1 low, beat 0 low
  typedef logic [4*`REPLAY_HALF_W-1:0] replay_word_t;

  // One pointer per queue
  typedef ptr_t [`REPLAY_NUM_QUEUES-1:0] queue_ptrs_t;

  // One bit per queue
  typedef logic [`REPLAY_NUM_QUEUES-1:0] queue_flags_t;

endpackage

// File: source/fallthrough_fifo.sv
/* First-word-fall-through FIFO with a type parameter for its payload,
   nearly-full and programmable-full flags from one occupancy counter */

`timescale 1ns/1ps

module fallthrough_fifo #(
  parameter type payload_t   = logic [7:0],
  parameter int  DEPTH_BITS  = 4,
  parameter int  PROG_MARGIN = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t din,
  input  logic     push,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     nearly_full,
  output logic     prog_full
);

  localparam int DEPTH = 1 << DEPTH_BITS;
  localparam logic [DEPTH_BITS:0] FULL_LEVEL = (DEPTH_BITS+1)'(DEPTH);
  localparam logic [DEPTH_BITS:0] NEAR_LEVEL = (DEPTH_BITS+1)'(DEPTH - 1);
  localparam logic [DEPTH_BITS:0] PROG_LEVEL = (DEPTH_BITS+1)'(DEPTH - PROG_MARGIN);

  payload_t              mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  // A push into a full buffer or a pop from an empty one is dropped
  assign wr_en = push && (count != FULL_LEVEL);
  assign rd_en = pop && (count != '0);

  // Head entry is always visible
  assign dout        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign nearly_full = (count >= NEAR_LEVEL);
  assign prog_full   = (count >= PROG_LEVEL);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (DEPTH_BITS+1)'(wr_en) - (DEPTH_BITS+1)'(rd_en);
    end
  end

endmodule

// File: source/queue_arbiter.sv
/* Round-robin read arbiter: head pointers, eligible-queue search and
   issue of one memory read with its tag every second cycle at most */

`timescale 1ns/1ps
`include "replay_settings.svh"

module queue_arbiter import replay_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         cal_done,
  input  queue_ptrs_t  tails,
  input  queue_flags_t out_prog_full,
  input  logic         mem_busy,
  input  logic         tag_full,
  output mem_req_t     mem_req,
  output qid_t         tag,
  output logic         tag_push,
  output queue_ptrs_t  heads
);

  typedef enum logic {
    ST_SELECT,
    ST_ISSUE
  } arb_state_t;

  arb_state_t   state;
  qid_t         last_qid;
  qid_t         cur_qid;
  qid_t         pick_qid;
  logic         pick_found;
  queue_flags_t eligible;
  logic         issue;

  // Words pending and room downstream
  always_comb begin
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      eligible[q] = cal_done && (heads[q] != tails[q]) && !out_prog_full[q];
    end
  end

  // Rotating priority, starting after the last served queue
  always_comb begin
    qid_t cand;
    pick_found = 1'b0;
    pick_qid   = last_qid;
    for (int i = 1; i <= `REPLAY_NUM_QUEUES; i++) begin
      cand = last_qid + qid_t'(i);
      if (!pick_found && eligible[cand]) begin
        pick_found = 1'b1;
        pick_qid   = cand;
      end
    end
  end

  // Request holds off while memory or tag FIFO can't take it
  assign issue = (state == ST_ISSUE) && !mem_busy && !tag_full;

  assign mem_req.valid = issue;
  assign mem_req.addr  = {cur_qid, heads[cur_qid]};
  assign tag           = cur_qid;
  assign tag_push      = issue;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_SELECT;
      last_qid <= qid_t'(`REPLAY_NUM_QUEUES - 1);
      cur_qid  <= '0;
      heads    <= '0;
    end else begin
      case (state)
        ST_SELECT: begin
          if (pick_found) begin
            cur_qid <= pick_qid;
            state   <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (issue) begin
            heads[cur_qid] <= heads[cur_qid] + 1'b1;
            last_qid       <= cur_qid;
            state          <= ST_SELECT;
          end
        end
        default: state <= ST_SELECT;
      endcase
    end
  end

endmodule

// File: source/beat_assembler.sv
/* Joins the two buffered response beats of a read with its tag into one
   output word and steers it to the tagged queue */

`timescale 1ns/1ps

module beat_assembler import replay_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  qid_t         tag,
  input  logic         tag_empty,
  input  mem_beat_t    beat,
  input  logic         beat_empty,
  output logic         tag_pop,
  output logic         beat_pop,
  output replay_word_t word,
  output queue_flags_t word_push
);

  mem_beat_t beat0_q;
  logic      beat0_valid;
  logic      take_beat0;
  logic      have_pair;

  // First beat of a read goes into the holding register
  assign take_beat0 = !beat0_valid && !beat_empty;

  // Second beat at the FIFO head and the tag of that read
  assign have_pair = beat0_valid && !beat_empty && !tag_empty;

  assign beat_pop = take_beat0 || have_pair;
  assign tag_pop  = have_pair;

  assign word = {beat.hi, beat0_q.hi, beat.lo, beat0_q.lo};

  // One-hot write strobe for the tagged output FIFO
  always_comb begin
    word_push = '0;
    if (have_pair) begin
      word_push[tag] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take_beat0) begin
      beat0_q <= beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat0_valid <= 1'b0;
    end else if (take_beat0) begin
      beat0_valid <= 1'b1;
    end else if (have_pair) begin
      beat0_valid <= 1'b0;
    end
  end

endmodule

// File: source/replay_top.sv
/* Replay read engine top: arbiter, tag and beat FIFOs, beat assembler
   and one output FIFO per queue */

`timescale 1ns/1ps
`include "replay_settings.svh"

module replay_top import replay_pkg::*; (
  input  logic                                    clk,
  input  logic                                    rst,
  output mem_req_t                                mem_req,
  input  logic                                    mem_busy,
  input  mem_resp_t                               mem_resp,
  input  queue_ptrs_t                             tails,
  input  logic                                    cal_done,
  output queue_ptrs_t                             heads,
  output queue_flags_t                            out_valid,
  output replay_word_t [`REPLAY_NUM_QUEUES-1:0]   out_data,
  input  queue_flags_t                            out_pop
);

  logic         eng_rst;
  qid_t         tag_in;
  logic         tag_push;
  logic         tag_full;
  qid_t         tag_out;
  logic         tag_empty;
  logic         tag_pop;
  mem_beat_t    beat_out;
  logic         beat_empty;
  logic         beat_pop;
  replay_word_t word;
  queue_flags_t word_push;
  queue_flags_t out_empty;
  queue_flags_t out_prog_full;

  // Engine held in reset until memory calibration is done
  assign eng_rst   = rst | ~cal_done;
  assign out_valid = ~out_empty;

  queue_arbiter arbiter_i (
    .clk           (clk),
    .rst           (eng_rst),
    .cal_done      (cal_done),
    .tails         (tails),
    .out_prog_full (out_prog_full),
    .mem_busy      (mem_busy),
    .tag_full      (tag_full),
    .mem_req       (mem_req),
    .tag           (tag_in),
    .tag_push      (tag_push),
    .heads         (heads)
  );

  // Queue index of every read in flight
  fallthrough_fifo #(
    .payload_t  (qid_t),
    .DEPTH_BITS (`REPLAY_TAG_DEPTH_BITS)
  ) tag_fifo_i (
    .clk         (clk),
    .rst         (eng_rst),
    .din         (tag_in),
    .push        (tag_push),
    .pop         (tag_pop),
    .dout        (tag_out),
    .empty       (tag_empty),
    .nearly_full (tag_full),
    .prog_full   ()
  );

  fallthrough_fifo #(
    .payload_t  (mem_beat_t),
    .DEPTH_BITS (`REPLAY_TAG_DEPTH_BITS)
  ) beat_fifo_i (
    .clk         (clk),
    .rst         (eng_rst),
    .din         (mem_resp.beat),
    .push        (mem_resp.valid),
    .pop         (beat_pop),
    .dout        (beat_out),
    .empty       (beat_empty),
    .nearly_full (),
    .prog_full   ()
  );

  beat_assembler assembler_i (
    .clk        (clk),
    .rst        (eng_rst),
    .tag        (tag_out),
    .tag_empty  (tag_empty),
    .beat       (beat_out),
    .beat_empty (beat_empty),
    .tag_pop    (tag_pop),
    .beat_pop   (beat_pop),
    .word       (word),
    .word_push  (word_push)
  );

  for (genvar q = 0; q < `REPLAY_NUM_QUEUES; q++) begin : g_out
    fallthrough_fifo #(
      .payload_t   (replay_word_t),
      .DEPTH_BITS  (`REPLAY_OUT_DEPTH_BITS),
      .PROG_MARGIN (`REPLAY_OUT_PROG_MARGIN)
    ) out_fifo_i (
      .clk         (clk),
      .rst         (eng_rst),
      .din         (word),
      .push        (word_push[q]),
      .pop         (out_pop[q]),
      .dout        (out_data[q]),
      .empty       (out_empty[q]),
      .nearly_full (),
      .prog_full   (out_prog_full[q])
    );
  end

endmodule

// File: tb/replay_mem_model.sv
/* Pipelined memory model: fixed read latency, one busy cycle per period,
   two response beats per read filled with an address pattern */

`timescale 1ns/1ps
`include "replay_settings.svh"

module replay_mem_model import replay_pkg::*; #(
  parameter int LATENCY     = 5,
  parameter int BUSY_PERIOD = 7
) (
  input  logic      clk,
  input  logic      rst,
  input  mem_req_t  mem_req,
  output logic      mem_busy,
  output mem_resp_t mem_resp
);

  int unsigned                   cycle;
  int unsigned                   busy_cnt;
  int unsigned                   due_q [$];
  logic [`REPLAY_MEM_ADDR_W-1:0] addr_q [$];
  logic                          second_beat;

  // Address on top, then beat and half index, zeros below
  function automatic logic [`REPLAY_HALF_W-1:0] fill_half(
    logic [`REPLAY_MEM_ADDR_W-1:0] addr, logic beat_idx, logic half_idx);
    return {addr, beat_idx, half_idx, {(`REPLAY_HALF_W-`REPLAY_MEM_ADDR_W-2){1'b0}}};
  endfunction

  // Busy in the last cycle of every period
  assign mem_busy = (busy_cnt == BUSY_PERIOD - 1);

  always @(posedge clk) begin
    if (rst) begin
      cycle       <= 0;
      busy_cnt    <= 0;
      second_beat <= 1'b0;
      mem_resp    <= '0;
      due_q.delete();
      addr_q.delete();
    end else begin
      cycle    <= cycle + 1;
      busy_cnt <= (busy_cnt == BUSY_PERIOD - 1) ? 0 : busy_cnt + 1;
      mem_resp <= '0;
      if (mem_req.valid && !mem_busy) begin
        addr_q.push_back(mem_req.addr);
        due_q.push_back(cycle + LATENCY);
      end
      // Oldest read answers once its latency has run out
      if (addr_q.size() > 0 && due_q[0] <= cycle) begin
        mem_resp.valid   <= 1'b1;
        mem_resp.beat.hi <= fill_half(addr_q[0], second_beat, 1'b1);
        mem_resp.beat.lo <= fill_half(addr_q[0], second_beat, 1'b0);
        second_beat      <= !second_beat;
        if (second_beat) begin
          addr_q.pop_front();
          due_q.pop_front();
        end
      end
    end
  end

endmodule

// File: tb/replay_assert.sv
/* Protocol assertions for the replay engine top, bound into replay_top */

`timescale 1ns/1ps
`include "replay_settings.svh"

module replay_assert import replay_pkg::*; (
  input logic         clk,
  input logic         rst,
  input logic         cal_done,
  input mem_req_t     mem_req,
  input logic         mem_busy,
  input queue_flags_t out_valid,
  input queue_flags_t out_pop,
  input queue_flags_t word_push
);

  localparam int unsigned OUT_DEPTH = 1 << `REPLAY_OUT_DEPTH_BITS;

  int unsigned fail_count = 0;
  int unsigned occupancy [`REPLAY_NUM_QUEUES];

  // Output FIFO fill level as seen from its ports
  always @(posedge clk) begin
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      if (rst || !cal_done) begin
        occupancy[q] <= 0;
      end else begin
        occupancy[q] <= occupancy[q] + (word_push[q] ? 1 : 0)
                        - ((out_valid[q] && out_pop[q]) ? 1 : 0);
      end
    end
  end

  no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
    mem_busy |-> !mem_req.valid)
    else begin
      $error("read request raised while memory is busy");
      fail_count++;
    end

  valid_low_after_reset: assert property (@(posedge clk) rst |=> (out_valid == '0))
    else begin
      $error("output valid set in the cycle after reset");
      fail_count++;
    end

  for (genvar q = 0; q < `REPLAY_NUM_QUEUES; q++) begin : g_push
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
      word_push[q] |-> (occupancy[q] < OUT_DEPTH))
      else begin
        $error("word pushed into full output FIFO %0d", q);
        fail_count++;
      end
  end

endmodule

// File: tb/replay_tb.sv
/* Replay engine testbench with clock and reset, memory model, output
   checker, directed tests, timeout and result */

`timescale 1ns/1ps
`include "replay_settings.svh"

module replay_tb import replay_pkg::*; ();

  // Roughly 125 reads of a few cycles each plus the observation windows
  localparam int unsigned TIMEOUT_CYCLES = 4000;

  logic                                  clk;
  logic                                  rst;
  logic                                  cal_done;
  logic                                  mem_busy;
  mem_req_t                              mem_req;
  mem_resp_t                             mem_resp;
  queue_ptrs_t                           tails;
  queue_ptrs_t                           heads;
  queue_flags_t                          out_valid;
  queue_flags_t                          out_pop;
  replay_word_t [`REPLAY_NUM_QUEUES-1:0] out_data;

  int unsigned                   cycle_count = 0;
  int unsigned                   reads_after_busy;
  logic                          busy_before;
  int unsigned                   rx_count [`REPLAY_NUM_QUEUES];
  logic [`REPLAY_MEM_ADDR_W-1:0] req_log [$];

  replay_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_busy (mem_busy),
    .mem_resp (mem_resp),
    .tails    (tails),
    .cal_done (cal_done),
    .heads    (heads),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_pop  (out_pop)
  );

  replay_mem_model #(.LATENCY(5), .BUSY_PERIOD(7)) mem_i (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_busy (mem_busy),
    .mem_resp (mem_resp)
  );

  bind replay_top replay_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .cal_done (cal_done),
    .mem_req  (mem_req),
    .mem_busy (mem_busy),
    .out_valid(out_valid),
    .out_pop  (out_pop),
    .word_push(word_push)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic fail_check(string msg);
    $display("Error at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_word(string name, replay_word_t exp, replay_word_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_ptr(string name, ptr_t exp, ptr_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flags(string name, queue_flags_t exp, queue_flags_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // Expected word of queue q at ring slot idx from the memory pattern rule
  function automatic replay_word_t expected_word(qid_t q, ptr_t idx);
    logic [`REPLAY_MEM_ADDR_W-1:0] a;
    logic [`REPLAY_HALF_W-15:0]    z;
    a = {q, idx};
    z = '0;
    return {a, 2'b11, z, a, 2'b01, z, a, 2'b10, z, a, 2'b00, z};
  endfunction

  function automatic queue_flags_t qid_onehot(qid_t q);
    queue_flags_t f;
    f    = '0;
    f[q] = 1'b1;
    return f;
  endfunction

  function automatic logic words_done(queue_ptrs_t want);
    logic done;
    done = 1'b1;
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      if (rx_count[q] < want[q]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  // Accepted reads and popped words sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (mem_req.valid && !mem_busy) begin
        req_log.push_back(mem_req.addr);
        // Read taken right after a busy cycle
        if (busy_before) begin
          reads_after_busy++;
        end
      end
      busy_before = mem_busy;
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        if (out_valid[q] && out_pop[q]) begin
          if (rx_count[q] >= tails[q]) begin
            fail_check($sformatf("queue %0d delivered a word beyond its tail", q));
          end
          check_word($sformatf("out_data[%0d]", q),
                     expected_word(qid_t'(q), ptr_t'(rx_count[q])), out_data[q]);
          rx_count[q]++;
        end
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst      <= 1'b1;
    cal_done <= 1'b0;
    tails    <= '0;
    out_pop  <= '0;
    repeat (3) @(posedge clk);
    req_log.delete();
    reads_after_busy = 0;
    busy_before      = 1'b0;
    for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
      rx_count[q] = 0;
    end
    rst <= 1'b0;
  endtask

  task automatic wait_for_words(queue_ptrs_t want);
    while (!words_done(want)) begin
      @(posedge clk);
    end
  endtask

  // Each queue's reads must walk its ring from zero up to the tail
  task automatic check_request_order(queue_ptrs_t want);
    ptr_t next [`REPLAY_NUM_QUEUES];
    qid_t q;
    for (int i = 0; i < `REPLAY_NUM_QUEUES; i++) begin
      next[i] = '0;
    end
    foreach (req_log[n]) begin
      q = req_log[n][`REPLAY_MEM_ADDR_W-1 -: `REPLAY_QID_W];
      check_ptr($sformatf("request pointer of queue %0d", q), next[q],
                req_log[n][`REPLAY_PTR_W-1:0]);
      next[q] = next[q] + 1'b1;
    end
    for (int i = 0; i < `REPLAY_NUM_QUEUES; i++) begin
      check_ptr($sformatf("request count of queue %0d", i), want[i], next[i]);
      check_ptr($sformatf("heads[%0d]", i), want[i], heads[i]);
    end
  endtask

  task automatic run_queues(queue_ptrs_t t, queue_flags_t pop);
    @(posedge clk);
    tails    <= t;
    cal_done <= 1'b1;
    out_pop  <= pop;
  endtask

  task automatic idle_without_cal();
    apply_reset();
    @(posedge clk);
    tails <= {`REPLAY_NUM_QUEUES{ptr_t'(3)}};
    repeat (20) begin
      @(negedge clk);
      check_flags("out_valid", '0, out_valid);
      for (int q = 0; q < `REPLAY_NUM_QUEUES; q++) begin
        check_ptr($sformatf("heads[%0d]", q), '0, heads[q]);
      end
      if (mem_req.valid) begin
        fail_check("memory request raised while cal_done is low");
      end
    end
  endtask

  task automatic single_queue_words();
    queue_ptrs_t t;
    t    = '0;
    t[2] = ptr_t'(5);
    apply_reset();
    run_queues(t, '1);
    wait_for_words(t);
    check_request_order(t);
  endtask

  task automatic round_robin_order();
    queue_ptrs_t t;
    t = {`REPLAY_NUM_QUEUES{ptr_t'(6)}};
    apply_reset();
    run_queues(t, '1);
    wait_for_words(t);
    if (req_log.size() != 24) begin
      fail_check($sformatf("expected 24 reads, saw %0d", req_log.size()));
    end
    foreach (req_log[n]) begin
      check_flags($sformatf("queue of read %0d", n), qid_onehot(qid_t'(n % 4)),
                  qid_onehot(req_log[n][`REPLAY_MEM_ADDR_W-1 -: `REPLAY_QID_W]));
    end
    check_request_order(t);
  endtask

  task automatic backpressure_hold();
    queue_ptrs_t t;
    queue_ptrs_t others;
    ptr_t        held;
    t         = {`REPLAY_NUM_QUEUES{ptr_t'(8)}};
    t[1]      = ptr_t'(30);
    others    = t;
    others[1] = '0;
    apply_reset();
    run_queues(t, 4'b1101);
    wait_for_words(others);
    // Let queue 1 fill up to its programmable-full level
    repeat (50) @(posedge clk);
    @(negedge clk);
    held = heads[1];
    if (held >= ptr_t'(30)) begin
      fail_check("queue 1 head reached its tail although nothing was popped");
    end
    check_flags("out_valid", 4'b0010, out_valid);
    repeat (20) @(negedge clk);
    check_ptr("heads[1] while stalled", held, heads[1]);
    @(posedge clk);
    out_pop <= '1;
    wait_for_words(t);
    check_request_order(t);
  endtask

  task automatic busy_stall_order();
    queue_ptrs_t t;
    t = {`REPLAY_NUM_QUEUES{ptr_t'(10)}};
    apply_reset();
    run_queues(t, '1);
    wait_for_words(t);
    if (reads_after_busy == 0) begin
      fail_check("no read was accepted right after a memory busy cycle");
    end
    check_request_order(t);
  endtask

  initial begin
    rst      = 1'b1;
    cal_done = 1'b0;
    tails    = '0;
    out_pop  = '0;
    idle_without_cal();
    single_queue_words();
    round_robin_order();
    backpressure_hold();
    busy_stall_order();
    repeat (5) @(posedge clk);
    if (dut_i.assert_i.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d protocol assertions failed", dut_i.assert_i.fail_count);
      stop_run();
    end
  end

endmodule

// File: tb.f
+incdir+source
source/replay_pkg.sv
source/fallthrough_fifo.sv
source/queue_arbiter.sv
source/beat_assembler.sv
source/replay_top.sv
tb/replay_mem_model.sv
tb/replay_assert.sv
tb/replay_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the replay testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module replay_tb \
    -Mdir obj_dir -o replay_sim \
  && ./obj_dir/replay_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || echo "Simulation finished without failure"
